// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - cpu_alu.sv
  - cpu_decoder.sv
  - cpu_regfile.sv
  - cpu_mem.sv
  - cpu_pc.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_props.sv
      - tb_cpu.sv

// ==== build.f ====
cpu_pkg.sv
cpu_alu.sv
cpu_decoder.sv
cpu_regfile.sv
cpu_mem.sv
cpu_pc.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

// ==== cpu_alu.sv ====
// ##########################################################
// integer alu
// ##########################################################
`timescale 1ns/10ps

module cpu_alu import cpu_pkg::*; (
  input  word_t    a,       // R[rt]
  input  word_t    b,       // R[rs]/R[rd] or immediate
  input  alu_op_t  op,
  input  reg_idx_t shamt,
  output word_t    result
);

  logic signed [31:0] sa;
  logic signed [31:0] sb;

  assign sa = a;
  assign sb = b;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_XOR: result = a ^ b;
      ALU_OR:  result = a | b;
      ALU_NOT: result = ~a;
      ALU_SLL: result = a << shamt;
      ALU_SRL: result = a >> shamt;  // logical
      // compares land in bit 0
      ALU_SNE: result = word_t'(sa != sb);
      ALU_SEQ: result = word_t'(sa == sb);
      ALU_SLT: result = word_t'(sa < sb);
      ALU_SLE: result = word_t'(sa <= sb);
      ALU_SGT: result = word_t'(sa > sb);
      ALU_SGE: result = word_t'(sa >= sb);
      ALU_LUI: result = b << 16;
      default: result = 32'hdeadbeef;  // marker for a bad op
    endcase
  end

endmodule

// ==== cpu_decoder.sv ====
// ##########################################################
// instruction decoder
// ##########################################################
`timescale 1ns/10ps

module cpu_decoder import cpu_pkg::*; (
  input  instr_t instr,
  output ctrl_t  ctrl
);

  always_comb begin
    ctrl        = '0;  // unknown codes write nothing
    ctrl.alu_op = ALU_BAD;
    case (instr.opcode)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        case (instr.func)
          FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:          ctrl.alu_op = ALU_AND;
          FN_OR:           ctrl.alu_op = ALU_OR;
          FN_NOT:          ctrl.alu_op = ALU_NOT;
          FN_XOR:          ctrl.alu_op = ALU_XOR;
          FN_SLT:          ctrl.alu_op = ALU_SLT;
          FN_SLL:          ctrl.alu_op = ALU_SLL;
          FN_SRL:          ctrl.alu_op = ALU_SRL;
          default:         ctrl.reg_write = 1'b0;  // bad func, no write
        endcase
      end
      OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SEQI, OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        case (instr.opcode)
          OP_ANDI: ctrl.alu_op = ALU_AND;
          OP_ORI:  ctrl.alu_op = ALU_OR;
          OP_XORI: ctrl.alu_op = ALU_XOR;
          OP_SLTI: ctrl.alu_op = ALU_SLT;
          OP_SEQI: ctrl.alu_op = ALU_SEQ;
          OP_LUI:  ctrl.alu_op = ALU_LUI;
          default: ctrl.alu_op = ALU_ADD;  // addi, addiu
        endcase
      end
      OP_LW: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.use_imm    = 1'b1;
        ctrl.alu_op     = ALU_ADD;  // address = R[rt] + imm
      end
      OP_SW: begin
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.store_src = 1'b1;      // store data is R[rd]
        ctrl.alu_op    = ALU_ADD;
      end
      OP_BEQ, OP_BNE, OP_BGT, OP_BGE, OP_BLT, OP_BLE: begin
        ctrl.branch    = 1'b1;
        ctrl.store_src = 1'b1;      // compare R[rt] with R[rd]
        case (instr.opcode)
          OP_BEQ:  ctrl.alu_op = ALU_SEQ;
          OP_BNE:  ctrl.alu_op = ALU_SNE;
          OP_BGT:  ctrl.alu_op = ALU_SGT;
          OP_BGE:  ctrl.alu_op = ALU_SGE;
          OP_BLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.alu_op = ALU_SLE;
        endcase
      end
      OP_J, OP_J2: begin
        ctrl.jump = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== cpu_mem.sv ====
// ##########################################################
// word memory
// ##########################################################
`timescale 1ns/10ps

module cpu_mem import cpu_pkg::*; (
  input  logic  clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  word_t wr_data,
  input  addr_t rd_addr,
  output word_t rd_data
);

  word_t mem [MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  assign rd_data = mem[rd_addr];  // async read

endmodule

// ==== cpu_pc.sv ====
// ##########################################################
// program counter
// ##########################################################
`timescale 1ns/10ps

module cpu_pc import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  jump,
  input  addr_t target,
  input  logic  branch_taken,
  input  word_t offset,        // sign-extended imm
  output addr_t pc
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (jump) begin
      pc <= target;
    end else if (branch_taken) begin
      pc <= pc + 10'd1 + offset[9:0];  // relative to the next instr
    end else if (pc != HALT_PC) begin
      pc <= pc + 10'd1;
    end
    // parked at HALT_PC otherwise
  end

endmodule

// ==== cpu_pkg.sv ====
// ##########################################################
// single-cycle cpu shared definitions
// ##########################################################

package cpu_pkg;

  // widths that carry a meaning
  typedef logic [31:0] word_t;
  typedef logic [9:0]  addr_t;     // imem/dmem word address and pc
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  func_t;
  typedef logic [4:0]  alu_op_t;

  localparam int    MEM_DEPTH = 1024;
  localparam int    NUM_REGS  = 32;
  localparam addr_t HALT_PC   = 10'd100;  // pc parks here, done goes high

  // opcodes
  localparam opcode_t OP_RTYPE = 6'd0;
  localparam opcode_t OP_ADDI  = 6'd1;
  localparam opcode_t OP_ANDI  = 6'd2;
  localparam opcode_t OP_ORI   = 6'd3;
  localparam opcode_t OP_XORI  = 6'd4;
  localparam opcode_t OP_ADDIU = 6'd5;
  localparam opcode_t OP_LW    = 6'd7;
  localparam opcode_t OP_SW    = 6'd8;
  localparam opcode_t OP_SLTI  = 6'd9;
  localparam opcode_t OP_SEQI  = 6'd10;
  localparam opcode_t OP_LUI   = 6'd11;
  localparam opcode_t OP_BEQ   = 6'd16;
  localparam opcode_t OP_BNE   = 6'd17;
  localparam opcode_t OP_BGT   = 6'd18;
  localparam opcode_t OP_BGE   = 6'd19;
  localparam opcode_t OP_BLT   = 6'd20;
  localparam opcode_t OP_BLE   = 6'd21;
  localparam opcode_t OP_J     = 6'd24;
  localparam opcode_t OP_J2    = 6'd25;

  // r-type function field
  localparam func_t FN_ADD  = 6'd0;
  localparam func_t FN_SUB  = 6'd1;
  localparam func_t FN_AND  = 6'd2;
  localparam func_t FN_OR   = 6'd3;
  localparam func_t FN_NOT  = 6'd4;
  localparam func_t FN_XOR  = 6'd5;
  localparam func_t FN_ADDU = 6'd6;
  localparam func_t FN_SUBU = 6'd7;
  localparam func_t FN_SLT  = 6'd8;
  localparam func_t FN_SLL  = 6'd9;
  localparam func_t FN_SRL  = 6'd10;

  // alu operations
  localparam alu_op_t ALU_ADD = 5'd0;
  localparam alu_op_t ALU_SUB = 5'd1;
  localparam alu_op_t ALU_AND = 5'd2;
  localparam alu_op_t ALU_XOR = 5'd3;
  localparam alu_op_t ALU_OR  = 5'd4;
  localparam alu_op_t ALU_NOT = 5'd5;
  localparam alu_op_t ALU_SLL = 5'd6;
  localparam alu_op_t ALU_SRL = 5'd7;
  localparam alu_op_t ALU_SNE = 5'd8;
  localparam alu_op_t ALU_SEQ = 5'd9;
  localparam alu_op_t ALU_SLT = 5'd10;
  localparam alu_op_t ALU_SLE = 5'd11;
  localparam alu_op_t ALU_SGT = 5'd12;
  localparam alu_op_t ALU_SGE = 5'd13;
  localparam alu_op_t ALU_LUI = 5'd14;
  localparam alu_op_t ALU_BAD = 5'd31;

  // imm and jump target overlay the low bits
  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rt;
    reg_idx_t rs;
    reg_idx_t shamt;
    func_t    func;
  } instr_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_write;
    logic    mem_to_reg;
    logic    use_imm;
    logic    branch;
    logic    jump;
    logic    store_src;  // second read port takes rd
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    logic  to_imem;
    addr_t addr;
    word_t data;
  } load_req_t;

  typedef struct packed {
    word_t r1;
    word_t r2;
    word_t r3;
    word_t r4;
    word_t r5;
  } watch_regs_t;

endpackage

// ==== cpu_props.sv ====
// ##########################################################
// cpu top properties
// ##########################################################
`timescale 1ns/10ps

module cpu_props import cpu_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      load_valid,
  input load_req_t load,
  input logic      done
);

  // pc is cleared by reset, so done must be low next cycle
  done_low_after_rst: assert property (@(posedge clk) rst |=> !done)
    else $error("done high in the cycle after reset");

  // parked core holds done
  done_sticky: assert property (@(posedge clk) done && !rst |=> done)
    else $error("done dropped without reset");

  load_known: assert property (@(posedge clk) load_valid |-> !$isunknown(load))
    else $error("load fields unknown while load_valid is high");

endmodule

bind cpu_top cpu_props props0 (.*);

// ==== cpu_regfile.sv ====
// ##########################################################
// integer register file
// ##########################################################
`timescale 1ns/10ps

module cpu_regfile import cpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  reg_idx_t    rd_a_idx,
  input  reg_idx_t    rd_b_idx,
  output word_t       rd_a,
  output word_t       rd_b,
  input  logic        wr_en,
  input  reg_idx_t    wr_idx,
  input  word_t       wr_data,
  output watch_regs_t watch
);

  word_t regs [NUM_REGS];

  // r0 is writable like any other
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rd_a = regs[rd_a_idx];
  assign rd_b = regs[rd_b_idx];

  assign watch.r1 = regs[1];
  assign watch.r2 = regs[2];
  assign watch.r3 = regs[3];
  assign watch.r4 = regs[4];
  assign watch.r5 = regs[5];

endmodule

// ==== cpu_top.sv ====
// ##########################################################
// single-cycle cpu top
// ##########################################################
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        load_valid,
  input  load_req_t   load,
  output watch_regs_t watch,
  output logic        done
);

  addr_t    pc;
  instr_t   instr;
  ctrl_t    ctrl;
  word_t    imm_ext;
  reg_idx_t rd_b_idx;
  word_t    rd_a;
  word_t    rd_b;
  word_t    alu_b;
  word_t    alu_result;
  word_t    dmem_rd_data;
  word_t    wb_data;
  logic     imem_load;
  logic     dmem_load;
  logic     store_en;
  logic     dmem_wr_en;
  addr_t    dmem_wr_addr;
  word_t    dmem_wr_data;

  assign imm_ext  = {{16{instr[15]}}, instr[15:0]};
  assign rd_b_idx = ctrl.store_src ? instr.rd : instr.rs;
  assign alu_b    = ctrl.use_imm ? imm_ext : rd_b;
  assign wb_data  = ctrl.mem_to_reg ? dmem_rd_data : alu_result;

  // external load port, split by target memory
  assign imem_load = load_valid & load.to_imem;
  assign dmem_load = load_valid & ~load.to_imem;

  // no stores while held in reset; a load beats a store
  assign store_en     = ctrl.mem_write & ~rst;
  assign dmem_wr_en   = dmem_load | store_en;
  assign dmem_wr_addr = dmem_load ? load.addr : alu_result[9:0];
  assign dmem_wr_data = dmem_load ? load.data : rd_b;

  assign done = (pc == HALT_PC);

  cpu_pc pc0 (
    .clk          (clk),
    .rst          (rst),
    .jump         (ctrl.jump),
    .target       (instr[9:0]),  // low bits of the 26-bit target
    .branch_taken (ctrl.branch & alu_result[0]),
    .offset       (imm_ext),
    .pc           (pc)
  );

  cpu_mem imem0 (
    .clk     (clk),
    .wr_en   (imem_load),
    .wr_addr (load.addr),
    .wr_data (load.data),
    .rd_addr (pc),
    .rd_data (instr)
  );

  cpu_decoder decoder0 (
    .instr (instr),
    .ctrl  (ctrl)
  );

  cpu_regfile regfile0 (
    .clk      (clk),
    .rst      (rst),
    .rd_a_idx (instr.rt),
    .rd_b_idx (rd_b_idx),
    .rd_a     (rd_a),
    .rd_b     (rd_b),
    .wr_en    (ctrl.reg_write),
    .wr_idx   (instr.rd),
    .wr_data  (wb_data),
    .watch    (watch)
  );

  cpu_alu alu0 (
    .a      (rd_a),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .shamt  (instr.shamt),
    .result (alu_result)
  );

  cpu_mem dmem0 (
    .clk     (clk),
    .wr_en   (dmem_wr_en),
    .wr_addr (dmem_wr_addr),
    .wr_data (dmem_wr_data),
    .rd_addr (alu_result[9:0]),
    .rd_data (dmem_rd_data)
  );

endmodule

// ==== tb_cpu.sv ====
// ##########################################################
// single-cycle cpu testbench
// ##########################################################
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

  localparam int    NUM_CASES    = 8;
  localparam int    PROG_LEN     = 12;
  localparam int    DATA_LEN     = 4;
  localparam int    RESET_CYCLES = 8;
  localparam int    LOAD_WORDS   = PROG_LEN + 2 + DATA_LEN;  // + stop jump + halt nop
  localparam int    TIMEOUT_CYCLES =
    NUM_CASES * (LOAD_WORDS + RESET_CYCLES + int'(HALT_PC) + 10) + RESET_CYCLES;
  localparam word_t NOP_WORD     = 32'hfc000000;  // opcode 63 decodes to nothing

  logic        clk = 1'b0;
  logic        rst;
  logic        load_valid;
  load_req_t   load;
  watch_regs_t watch;
  logic        done;

  word_t       prog_tab [NUM_CASES][PROG_LEN];
  word_t       data_tab [NUM_CASES][DATA_LEN];
  watch_regs_t exp_tab  [NUM_CASES];
  int          cur_case = 0;
  int          cycles   = 0;

  cpu_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load       (load),
    .watch      (watch),
    .done       (done)
  );

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: done was not reached within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "run stopped on timeout");
    end
  end

  // op | rd | rt | rs | shamt | func with imm in the low 16 bits
  function automatic word_t encode_r(func_t fn, reg_idx_t rd, reg_idx_t rt,
                                     reg_idx_t rs, reg_idx_t sh);
    return {OP_RTYPE, rd, rt, rs, sh, fn};
  endfunction

  function automatic word_t encode_i(opcode_t op, reg_idx_t rd, reg_idx_t rt,
                                     logic [15:0] imm);
    return {op, rd, rt, imm};
  endfunction

  function automatic word_t encode_j(opcode_t op, addr_t target);
    return {op, 16'd0, target};
  endfunction

  task automatic check_regs(input watch_regs_t exp);
    if (watch !== exp) begin
      $display("error at %0t: case %0d r1..r5 = %h %h %h %h %h, expected %h %h %h %h %h",
               $time, cur_case, watch.r1, watch.r2, watch.r3, watch.r4, watch.r5,
               exp.r1, exp.r2, exp.r3, exp.r4, exp.r5);
      $display("Simulation failed");
      $fatal(1, "stopped at first register mismatch");
    end
  endtask

  task automatic check_done(input logic exp);
    if (done !== exp) begin
      $display("error at %0t: case %0d done = %b, expected %b", $time, cur_case, done, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at first done mismatch");
    end
  endtask

  task automatic load_word(input logic to_imem, input addr_t addr, input word_t data);
    @(negedge clk);
    load_valid   = 1'b1;
    load.to_imem = to_imem;
    load.addr    = addr;
    load.data    = data;
  endtask

  task automatic build_table();
    for (int r = 0; r < NUM_CASES; r++) begin
      for (int i = 0; i < PROG_LEN; i++) begin
        prog_tab[r][i] = encode_j(OP_J, HALT_PC);
      end
      for (int i = 0; i < DATA_LEN; i++) begin
        data_tab[r][i] = 32'hd0000000 | word_t'(r * 16 + i);
      end
    end
    // first r-type half on 12 and -5
    prog_tab[0][0] = encode_i(OP_ADDI, 5'd6, 5'd0, 16'd12);
    prog_tab[0][1] = encode_i(OP_ADDI, 5'd7, 5'd0, 16'hfffb);
    prog_tab[0][2] = encode_r(FN_ADD, 5'd1, 5'd6, 5'd7, 5'd0);
    prog_tab[0][3] = encode_r(FN_SUB, 5'd2, 5'd6, 5'd7, 5'd0);
    prog_tab[0][4] = encode_r(FN_AND, 5'd3, 5'd6, 5'd7, 5'd0);
    prog_tab[0][5] = encode_r(FN_OR, 5'd4, 5'd6, 5'd7, 5'd0);
    prog_tab[0][6] = encode_r(FN_XOR, 5'd5, 5'd6, 5'd7, 5'd0);
    exp_tab[0] = '{32'd7, 32'd17, 32'd8, 32'hffffffff, 32'hfffffff7};
    // second r-type half with shifts
    prog_tab[1][0] = encode_i(OP_ADDI, 5'd6, 5'd0, 16'd12);
    prog_tab[1][1] = encode_i(OP_ADDI, 5'd7, 5'd0, 16'hfffb);
    prog_tab[1][2] = encode_r(FN_NOT, 5'd1, 5'd6, 5'd0, 5'd0);
    prog_tab[1][3] = encode_r(FN_ADDU, 5'd2, 5'd6, 5'd6, 5'd0);
    prog_tab[1][4] = encode_r(FN_SUBU, 5'd3, 5'd7, 5'd6, 5'd0);
    prog_tab[1][5] = encode_r(FN_SLT, 5'd4, 5'd7, 5'd6, 5'd0);    // -5 < 12
    prog_tab[1][6] = encode_r(FN_SLL, 5'd5, 5'd6, 5'd0, 5'd28);
    prog_tab[1][7] = encode_r(FN_SRL, 5'd5, 5'd5, 5'd0, 5'd4);    // logical so no sign fill
    exp_tab[1] = '{32'hfffffff3, 32'd24, 32'hffffffef, 32'd1, 32'h0c000000};
    // immediates
    prog_tab[2][0] = encode_i(OP_ADDI, 5'd1, 5'd0, 16'hff9c);    // -100
    prog_tab[2][1] = encode_i(OP_ANDI, 5'd3, 5'd1, 16'h0ff0);
    prog_tab[2][2] = encode_i(OP_XORI, 5'd3, 5'd3, 16'h0005);
    prog_tab[2][3] = encode_i(OP_ORI, 5'd3, 5'd3, 16'h7000);
    prog_tab[2][4] = encode_i(OP_ADDIU, 5'd3, 5'd3, 16'h000b);
    prog_tab[2][5] = encode_i(OP_SLTI, 5'd2, 5'd1, 16'h0000);    // negative gives 1
    prog_tab[2][6] = encode_i(OP_SLTI, 5'd4, 5'd3, 16'h0005);
    prog_tab[2][7] = encode_i(OP_SEQI, 5'd5, 5'd3, 16'h7fa0);
    prog_tab[2][8] = encode_i(OP_SEQI, 5'd4, 5'd4, 16'h0001);
    prog_tab[2][9] = encode_i(OP_LUI, 5'd1, 5'd0, 16'h8001);
    exp_tab[2] = '{32'h80010000, 32'd1, 32'h00007fa0, 32'd0, 32'd1};
    // memory with a store landing at 0x55
    data_tab[3][0] = 32'h11111111;
    data_tab[3][1] = 32'hcafef00d;
    data_tab[3][2] = 32'h00000005;
    data_tab[3][3] = 32'ha5a5a5a5;
    prog_tab[3][0] = encode_i(OP_LW, 5'd1, 5'd0, 16'd1);
    prog_tab[3][1] = encode_i(OP_LW, 5'd2, 5'd0, 16'd2);
    prog_tab[3][2] = encode_i(OP_ADDI, 5'd3, 5'd2, 16'h0040);
    prog_tab[3][3] = encode_i(OP_SW, 5'd1, 5'd3, 16'h0010);
    prog_tab[3][4] = encode_i(OP_LW, 5'd4, 5'd3, 16'h0010);
    prog_tab[3][5] = encode_i(OP_LW, 5'd5, 5'd2, 16'hfffe);
    exp_tab[3] = '{32'hcafef00d, 32'd5, 32'h45, 32'hcafef00d, 32'ha5a5a5a5};
    // branches on equal operands r0 and r0
    prog_tab[4][0]  = encode_i(OP_BEQ, 5'd0, 5'd0, 16'd1);
    prog_tab[4][1]  = encode_i(OP_ADDI, 5'd1, 5'd1, 16'd1);
    prog_tab[4][2]  = encode_i(OP_BGE, 5'd0, 5'd0, 16'd1);
    prog_tab[4][3]  = encode_i(OP_ADDI, 5'd2, 5'd2, 16'd1);
    prog_tab[4][4]  = encode_i(OP_BLE, 5'd0, 5'd0, 16'd1);
    prog_tab[4][5]  = encode_i(OP_ADDI, 5'd3, 5'd3, 16'd1);
    prog_tab[4][6]  = encode_i(OP_BNE, 5'd0, 5'd0, 16'd1);
    prog_tab[4][7]  = encode_i(OP_ADDI, 5'd4, 5'd4, 16'd1);
    prog_tab[4][8]  = encode_i(OP_BGT, 5'd0, 5'd0, 16'd1);
    prog_tab[4][9]  = encode_i(OP_ADDI, 5'd5, 5'd5, 16'd1);
    prog_tab[4][10] = encode_i(OP_BLT, 5'd0, 5'd0, 16'd1);
    prog_tab[4][11] = encode_i(OP_ADDI, 5'd1, 5'd1, 16'd2);
    exp_tab[4] = '{32'd2, 32'd0, 32'd0, 32'd1, 32'd1};
    // rt below rd with -2 against 0
    prog_tab[5][0]  = encode_i(OP_ADDI, 5'd6, 5'd0, 16'hfffe);
    prog_tab[5][1]  = encode_i(OP_BEQ, 5'd0, 5'd6, 16'd1);
    prog_tab[5][2]  = encode_i(OP_ADDI, 5'd1, 5'd1, 16'd1);
    prog_tab[5][3]  = encode_i(OP_BGE, 5'd0, 5'd6, 16'd1);
    prog_tab[5][4]  = encode_i(OP_ADDI, 5'd2, 5'd2, 16'd1);
    prog_tab[5][5]  = encode_i(OP_BNE, 5'd0, 5'd6, 16'd1);
    prog_tab[5][6]  = encode_i(OP_ADDI, 5'd3, 5'd3, 16'd1);
    prog_tab[5][7]  = encode_i(OP_BLT, 5'd0, 5'd6, 16'd1);
    prog_tab[5][8]  = encode_i(OP_ADDI, 5'd4, 5'd4, 16'd1);
    prog_tab[5][9]  = encode_i(OP_BLE, 5'd0, 5'd6, 16'd1);
    prog_tab[5][10] = encode_i(OP_ADDI, 5'd5, 5'd5, 16'd1);
    exp_tab[5] = '{32'd1, 32'd1, 32'd0, 32'd0, 32'd0};
    // rt above rd with 0 against -2
    prog_tab[6][0]  = encode_i(OP_ADDI, 5'd6, 5'd0, 16'hfffe);
    prog_tab[6][1]  = encode_i(OP_BGT, 5'd6, 5'd0, 16'd1);
    prog_tab[6][2]  = encode_i(OP_ADDI, 5'd1, 5'd1, 16'd1);
    prog_tab[6][3]  = encode_i(OP_BGE, 5'd6, 5'd0, 16'd1);
    prog_tab[6][4]  = encode_i(OP_ADDI, 5'd2, 5'd2, 16'd1);
    prog_tab[6][5]  = encode_i(OP_BLE, 5'd6, 5'd0, 16'd1);
    prog_tab[6][6]  = encode_i(OP_ADDI, 5'd3, 5'd3, 16'd1);
    prog_tab[6][7]  = encode_i(OP_BLT, 5'd6, 5'd0, 16'd1);
    prog_tab[6][8]  = encode_i(OP_ADDI, 5'd4, 5'd4, 16'd1);
    prog_tab[6][9]  = encode_i(OP_BNE, 5'd6, 5'd0, 16'd1);
    prog_tab[6][10] = encode_i(OP_ADDI, 5'd5, 5'd5, 16'd1);
    exp_tab[6] = '{32'd0, 32'd0, 32'd1, 32'd1, 32'd0};
    // jumps over writes using both jump opcodes
    prog_tab[7][0] = encode_i(OP_ADDI, 5'd1, 5'd0, 16'd7);
    prog_tab[7][1] = encode_j(OP_J, 10'd4);
    prog_tab[7][2] = encode_i(OP_ADDI, 5'd2, 5'd0, 16'd9);
    prog_tab[7][3] = encode_i(OP_ADDI, 5'd3, 5'd0, 16'd9);
    prog_tab[7][4] = encode_i(OP_ADDI, 5'd4, 5'd0, 16'h0044);
    prog_tab[7][5] = encode_j(OP_J2, 10'd7);
    prog_tab[7][6] = encode_i(OP_ADDI, 5'd5, 5'd0, 16'd1);
    prog_tab[7][7] = encode_i(OP_ADDI, 5'd5, 5'd4, 16'd1);
    exp_tab[7] = '{32'd7, 32'd0, 32'd0, 32'h44, 32'h45};
  endtask

  task automatic run_case(input int row);
    cur_case = row;
    rst      = 1'b1;
    // memories are loaded while the core is held in reset
    for (int i = 0; i < PROG_LEN; i++) begin
      load_word(1'b1, addr_t'(i), prog_tab[row][i]);
    end
    load_word(1'b1, addr_t'(PROG_LEN), encode_j(OP_J, HALT_PC));
    load_word(1'b1, HALT_PC, NOP_WORD);  // parked core fetches a nop
    for (int i = 0; i < DATA_LEN; i++) begin
      load_word(1'b0, addr_t'(i), data_tab[row][i]);
    end
    @(negedge clk);
    load_valid = 1'b0;
    repeat (RESET_CYCLES - 1) @(negedge clk);
    rst = 1'b0;
    check_done(1'b0);
    while (!done) @(negedge clk);
    repeat (2) @(negedge clk);  // parked core keeps done high
    check_done(1'b1);
    check_regs(exp_tab[row]);
  endtask

  initial begin
    rst        = 1'b1;
    load_valid = 1'b0;
    load       = '0;
    build_table();
    for (int r = 0; r < NUM_CASES; r++) begin
      run_case(r);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
